// ==== Bender.yml ====
package:
  name: shared_reg_hub

sources:
  - common/hub_pkg.sv
  - rtl/rr_arbiter.sv
  - rtl/axil_port.sv
  - rtl/reg_bank.sv
  - rtl/shared_reg_hub.sv
  - target: test
    files:
      - bench/hub_props.sv
      - bench/hub_tb.sv

// ==== bench/hub_props.sv ====
// ---------------------------------------------------------------------------
// concurrent assertions on the arbiter grant, the bank access and the
// response handshakes of the register hub
// ---------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module hub_props (
    input logic                                                   clock,
    input logic                                                   rst_n,
    input logic [hub_pkg::NUM_PORTS-1:0]                          grant,
    input logic [hub_pkg::NUM_PORTS-1:0]                          port_request,
    input logic                                                   access,
    input logic [hub_pkg::NUM_PORTS-1:0]                          bvalid,
    input logic [hub_pkg::NUM_PORTS-1:0]                          bready,
    input logic [hub_pkg::NUM_PORTS-1:0][1:0]                     bresp,
    input logic [hub_pkg::NUM_PORTS-1:0]                          rvalid,
    input logic [hub_pkg::NUM_PORTS-1:0]                          rready,
    input logic [hub_pkg::NUM_PORTS-1:0][hub_pkg::DATA_WIDTH-1:0] rdata,
    input logic [hub_pkg::NUM_PORTS-1:0][1:0]                     rresp
);

    import hub_pkg::*;

    // failures seen so far, read by the testbench at the end of the run
    int failures = 0;

    // at most one port owns the bank at a time
    a_grant_onehot: assert property (@(posedge clock) disable iff (!rst_n) $onehot0(grant))
        else begin
            $error("grant 0x%0h is neither one-hot nor zero", grant);
            failures++;
        end

    // a served holder has dropped its request by the next cycle, so the stale
    // grant it leaves behind must not reach the bank a second time
    a_access_granted: assert property (@(posedge clock) disable iff (!rst_n)
        access |=> !access)
        else begin
            $error("bank accessed again through a stale grant 0x%0h", grant);
            failures++;
        end

    // a response holds with its payload until the master takes it
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_hold
        a_bvalid_hold: assert property (@(posedge clock) disable iff (!rst_n)
            bvalid[i] && !bready[i] |=> bvalid[i] && $stable(bresp[i]))
            else begin
                $error("write response on port %0d changed before bready", i);
                failures++;
            end

        a_rvalid_hold: assert property (@(posedge clock) disable iff (!rst_n)
            rvalid[i] && !rready[i] |=> rvalid[i] && $stable(rdata[i]) && $stable(rresp[i]))
            else begin
                $error("read response on port %0d changed before rready", i);
                failures++;
            end
    end

endmodule

`default_nettype wire

// ==== bench/hub_tb.sv ====
// ---------------------------------------------------------------------------
// testbench for the shared register hub: clock, reset, directed and random
// AXI4-Lite traffic on all ports, a register model and the checks
// ---------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module hub_tb;

    import hub_pkg::*;

    localparam int unsigned SEED           = 32'h2709;
    localparam int          RANDOM_TXNS    = 200;
    localparam int          TIMEOUT_CYCLES = 200;

    logic                                 clock;
    logic                                 rst_n;
    logic [NUM_PORTS-1:0]                 awvalid;
    logic [NUM_PORTS-1:0]                 awready;
    logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0] awaddr;
    logic [NUM_PORTS-1:0]                 wvalid;
    logic [NUM_PORTS-1:0]                 wready;
    logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] wdata;
    logic [NUM_PORTS-1:0][STRB_WIDTH-1:0] wstrb;
    logic [NUM_PORTS-1:0]                 bvalid;
    logic [NUM_PORTS-1:0]                 bready;
    logic [NUM_PORTS-1:0][1:0]            bresp;
    logic [NUM_PORTS-1:0]                 arvalid;
    logic [NUM_PORTS-1:0]                 arready;
    logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0] araddr;
    logic [NUM_PORTS-1:0]                 rvalid;
    logic [NUM_PORTS-1:0]                 rready;
    logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] rdata;
    logic [NUM_PORTS-1:0][1:0]            rresp;

    // register model, updated in the order the bank answers
    logic [DATA_WIDTH-1:0] model [NUM_REGS];
    int                    served [$];
    int                    last_served = -1;
    int                    error_count = 0;
    int                    check_count = 0;
    bit                    timed_out = 1'b0;

    shared_reg_hub shared_reg_hub_inst (.*);

    bind shared_reg_hub hub_props hub_props_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .grant        (grant),
        .port_request (port_request),
        .access       (access),
        .bvalid       (bvalid),
        .bready       (bready),
        .bresp        (bresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // ------------------------------------------------------------------------
    // reference rules
    // ------------------------------------------------------------------------

    // only the bytes with their strobe bit set take the new value
    function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
                                                          input logic [DATA_WIDTH-1:0] new_word,
                                                          input logic [STRB_WIDTH-1:0] strb);
        logic [DATA_WIDTH-1:0] merged;
        merged = old_word;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (strb[b])
                merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

    // round robin picks the next pending index above the last one served, else the lowest
    function automatic int next_port(input logic [NUM_PORTS-1:0] pending, input int last);
        for (int i = last + 1; i < NUM_PORTS; i++) begin
            if (pending[i])
                return i;
        end
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (pending[i])
                return i;
        end
        return -1;
    endfunction

    // mostly legal addresses, with about one in eight past the end of the bank
    function automatic logic [ADDR_WIDTH-1:0] random_addr();
        if ($urandom_range(7) == 0)
            return $urandom | 32'h20;
        return $urandom_range(NUM_REGS * STRB_WIDTH - 1);
    endfunction

    // ------------------------------------------------------------------------
    // checking and AXI4-Lite driving
    // ------------------------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        assert (got === expected) else begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what, input int p);
        $display("timeout while waiting for %s on port %0d", what, p);
        error_count++;
        timed_out = 1'b1;
    endtask

    task automatic drive_request(input int p, input bit wr, input logic [ADDR_WIDTH-1:0] a,
                                 input logic [DATA_WIDTH-1:0] d, input logic [STRB_WIDTH-1:0] s);
        @(posedge clock);
        if (wr) begin
            awvalid[p] <= 1'b1;
            awaddr[p]  <= a;
            wvalid[p]  <= 1'b1;
            wdata[p]   <= d;
            wstrb[p]   <= s;
        end else begin
            arvalid[p] <= 1'b1;
            araddr[p]  <= a;
        end
    endtask

    // counts edges from the drive edge; ready is sampled half a cycle before each edge
    task automatic await_accept(input int p, input bit wr, output int edges);
        bit accepted;
        accepted = 1'b0;
        edges    = 0;
        while (!accepted && !timed_out) begin
            @(negedge clock);
            accepted = wr ? (awready[p] && wready[p]) : arready[p];
            @(posedge clock);
            edges++;
            if (!accepted && edges >= TIMEOUT_CYCLES)
                report_timeout(wr ? "awready and wready" : "arready", p);
        end
        awvalid[p] <= 1'b0;
        wvalid[p]  <= 1'b0;
        arvalid[p] <= 1'b0;
    endtask

    task automatic await_response(input int p, input bit wr, input logic [ADDR_WIDTH-1:0] a,
                                  input logic [DATA_WIDTH-1:0] d, input logic [STRB_WIDTH-1:0] s,
                                  inout int edges);
        bit                    seen;
        int                    idx;
        logic [1:0]            exp_resp;
        logic [DATA_WIDTH-1:0] exp_data;
        seen     = 1'b0;
        idx      = int'(a[REG_INDEX_WIDTH+1:2]);
        exp_resp = (a >= NUM_REGS * STRB_WIDTH) ? RESP_SLVERR : RESP_OKAY;
        while (!seen && !timed_out) begin
            @(negedge clock);
            seen = wr ? bvalid[p] : rvalid[p];
            if (!seen) begin
                @(posedge clock);
                edges++;
                if (edges >= TIMEOUT_CYCLES)
                    report_timeout(wr ? "bvalid" : "rvalid", p);
            end
        end
        if (seen) begin
            served.push_back(p);
            last_served = p;
            if (wr) begin
                check_value($sformatf("bresp[%0d]", p), bresp[p], exp_resp);
                if (exp_resp == RESP_OKAY)
                    model[idx] = merge_bytes(model[idx], d, s);
            end else begin
                exp_data = (exp_resp == RESP_OKAY) ? model[idx] : '0;
                check_value($sformatf("rresp[%0d]", p), rresp[p], exp_resp);
                check_value($sformatf("rdata[%0d]", p), rdata[p], exp_data);
            end
        end
    endtask

    // keeps bready or rready low for a while; the response must stay put and the
    // port must refuse new work until it is taken
    task automatic hold_and_release(input int p, input bit wr, input int hold);
        logic [1:0]            held_resp;
        logic [DATA_WIDTH-1:0] held_data;
        if (timed_out)
            return;
        @(negedge clock);
        held_resp = wr ? bresp[p] : rresp[p];
        held_data = rdata[p];
        for (int c = 0; c <= hold; c++) begin
            if (c > 0) begin
                @(posedge clock);
                @(negedge clock);
            end
            check_value($sformatf("%s[%0d]", wr ? "bvalid" : "rvalid", p),
                        wr ? bvalid[p] : rvalid[p], 1);
            check_value($sformatf("resp[%0d]", p), wr ? bresp[p] : rresp[p], held_resp);
            if (!wr)
                check_value($sformatf("rdata[%0d]", p), rdata[p], held_data);
            check_value($sformatf("awready[%0d]", p), awready[p], 0);
            check_value($sformatf("wready[%0d]", p), wready[p], 0);
            check_value($sformatf("arready[%0d]", p), arready[p], 0);
        end
        @(posedge clock);
        if (wr)
            bready[p] <= 1'b1;
        else
            rready[p] <= 1'b1;
        @(posedge clock);
        bready[p] <= 1'b0;
        rready[p] <= 1'b0;
    endtask

    task automatic transfer(input int p, input bit wr, input logic [ADDR_WIDTH-1:0] a,
                            input logic [DATA_WIDTH-1:0] d, input logic [STRB_WIDTH-1:0] s,
                            input int hold, output int edges);
        drive_request(p, wr, a, d, s);
        await_accept(p, wr, edges);
        await_response(p, wr, a, d, s, edges);
        hold_and_release(p, wr, hold);
    endtask

    task automatic random_traffic(input int p, input int count);
        bit                    wr;
        logic [ADDR_WIDTH-1:0] a;
        int                    edges;
        for (int n = 0; n < count && !timed_out; n++) begin
            wr = $urandom_range(1);
            a  = random_addr();
            transfer(p, wr, a, $urandom, $urandom_range(15), $urandom_range(3), edges);
            repeat ($urandom_range(2)) @(posedge clock);
        end
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin
        int unsigned           seed_state;
        int                    lat [NUM_PORTS];
        int                    exp_port;
        logic [NUM_PORTS-1:0]  pending;
        logic [ADDR_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] d;
        logic [STRB_WIDTH-1:0] s;
        seed_state = $urandom(SEED);
        rst_n   = 1'b0;
        awvalid = '0;
        awaddr  = '0;
        wvalid  = '0;
        wdata   = '0;
        wstrb   = '0;
        bready  = '0;
        arvalid = '0;
        araddr  = '0;
        rready  = '0;
        for (int r = 0; r < NUM_REGS; r++)
            model[r] = '0;
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;

        // nothing is ready or valid after reset, and every word reads zero
        @(negedge clock);
        check_value("awready", awready, 0);
        check_value("wready", wready, 0);
        check_value("arready", arready, 0);
        check_value("bvalid", bvalid, 0);
        check_value("rvalid", rvalid, 0);
        for (int r = 0; r < NUM_REGS; r++)
            transfer(0, 1'b0, r * STRB_WIDTH, '0, '0, 0, lat[0]);

        // uncontended write and readback, three edges from the drive edge to the response
        repeat (4) begin
            a = $urandom_range(NUM_REGS * STRB_WIDTH - 1);
            transfer(1, 1'b1, a, $urandom, $urandom_range(15), 0, lat[1]);
            check_value("write latency", lat[1], 3);
            transfer(1, 1'b0, a, '0, '0, 0, lat[1]);
            check_value("read latency", lat[1], 3);
        end

        // out of range write and read, then the aliased word must be unchanged
        a = $urandom | 32'h20;
        transfer(2, 1'b1, a, $urandom, 4'hf, 0, lat[2]);
        transfer(2, 1'b0, a, '0, '0, 0, lat[2]);
        transfer(2, 1'b0, a & 32'h1c, '0, '0, 0, lat[2]);

        // all three ports accept on the same edge
        served.delete();
        a = $urandom_range(NUM_REGS * STRB_WIDTH - 1);
        d = $urandom;
        pending = '1;
        exp_port = last_served;
        fork
            transfer(0, 1'b1, a, d, 4'hf, 0, lat[0]);
            transfer(1, 1'b0, a, '0, '0, 0, lat[1]);
            transfer(2, 1'b1, a, ~d, 4'h5, 0, lat[2]);
        join
        check_value("served count", served.size(), NUM_PORTS);
        for (int k = 0; k < NUM_PORTS && k < served.size(); k++) begin
            exp_port = next_port(pending, exp_port);
            pending[exp_port] = 1'b0;
            check_value($sformatf("served port %0d", k), served[k], exp_port);
        end

        // a read is offered while the write response is held back, then a
        // write is offered while the read response is held back
        a = $urandom_range(NUM_REGS * STRB_WIDTH - 1);
        d = $urandom;
        s = $urandom_range(15);
        drive_request(1, 1'b1, a, d, s);
        await_accept(1, 1'b1, lat[1]);
        await_response(1, 1'b1, a, d, s, lat[1]);
        drive_request(1, 1'b0, a, '0, '0);
        hold_and_release(1, 1'b1, 6);
        await_accept(1, 1'b0, lat[1]);
        await_response(1, 1'b0, a, '0, '0, lat[1]);
        drive_request(1, 1'b1, a, ~d, ~s);
        hold_and_release(1, 1'b0, 5);
        await_accept(1, 1'b1, lat[1]);
        await_response(1, 1'b1, a, ~d, ~s, lat[1]);
        hold_and_release(1, 1'b1, 0);

        // long random traffic on every port at once
        fork
            random_traffic(0, RANDOM_TXNS);
            random_traffic(1, RANDOM_TXNS);
            random_traffic(2, RANDOM_TXNS);
        join

        repeat (2) @(posedge clock);
        $display("checks: %0d, testbench errors: %0d, assertion failures: %0d",
                 check_count, error_count, shared_reg_hub_inst.hub_props_inst.failures);
        if (error_count == 0 && shared_reg_hub_inst.hub_props_inst.failures == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== common/hub_pkg.sv ====
// ---------------------------------------------------------------------------
// sizes and AXI response codes shared by the register hub
// ---------------------------------------------------------------------------

`default_nettype none

package hub_pkg;

    // number of AXI4-Lite requesters sharing the bank
    localparam int NUM_PORTS = 3;

    // AXI4-Lite address and data widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // one strobe bit per data byte
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // the bank holds eight words, so byte addresses 0 to 31 are legal
    localparam int NUM_REGS = 8;
    localparam int REG_INDEX_WIDTH = 3;

    // ------------------------------------------------------------------------
    // AXI response codes
    // ------------------------------------------------------------------------

    // normal completion
    localparam logic [1:0] RESP_OKAY = 2'd0;

    // address outside the bank
    localparam logic [1:0] RESP_SLVERR = 2'd2;

endpackage

`default_nettype wire

// ==== compile.f ====
common/hub_pkg.sv
rtl/rr_arbiter.sv
rtl/axil_port.sv
rtl/reg_bank.sv
rtl/shared_reg_hub.sv
bench/hub_props.sv
bench/hub_tb.sv

// ==== rtl/axil_port.sv ====
// ---------------------------------------------------------------------------
// per-requester AXI4-Lite slave that captures one transaction, raises a
// request towards the arbiter and returns the bank's answer
// ---------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module axil_port (
    input  logic                           clock,
    input  logic                           rst_n,

    // write address and write data
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [hub_pkg::ADDR_WIDTH-1:0] awaddr,
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [hub_pkg::DATA_WIDTH-1:0] wdata,
    input  logic [hub_pkg::STRB_WIDTH-1:0] wstrb,

    // write response
    output logic                           bvalid,
    input  logic                           bready,
    output logic [1:0]                     bresp,

    // read address
    input  logic                           arvalid,
    output logic                           arready,
    input  logic [hub_pkg::ADDR_WIDTH-1:0] araddr,

    // read data
    output logic                           rvalid,
    input  logic                           rready,
    output logic [hub_pkg::DATA_WIDTH-1:0] rdata,
    output logic [1:0]                     rresp,

    // held transaction towards the arbiter and the bank
    output logic                           request,
    output logic                           is_write,
    output logic [hub_pkg::ADDR_WIDTH-1:0] addr,
    output logic [hub_pkg::DATA_WIDTH-1:0] wr_data,
    output logic [hub_pkg::STRB_WIDTH-1:0] wr_strb,

    // completion from the bank
    input  logic                           done,
    input  logic [hub_pkg::DATA_WIDTH-1:0] done_rdata,
    input  logic                           done_err
);

    import hub_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_PENDING = 2'd1,
        ST_RESPOND = 2'd2
    } state_t;

    state_t     state;
    logic       write_valid;
    logic       write_fire;
    logic       read_fire;
    logic       resp_taken;
    logic [1:0] resp;

    // ------------------------------------------------------------------------
    // acceptance
    // ------------------------------------------------------------------------

    // a write needs address and data together, and it wins over a read
    assign write_valid = awvalid & wvalid;
    assign write_fire  = (state == ST_IDLE) & write_valid;
    assign read_fire   = (state == ST_IDLE) & arvalid & ~write_valid;

    // both write channels handshake in the same cycle
    assign awready = write_fire;
    assign wready  = write_fire;
    assign arready = read_fire;

    // the request is decoded from the state register, so it rises one edge
    // after acceptance
    assign request = (state == ST_PENDING);

    // ------------------------------------------------------------------------
    // response
    // ------------------------------------------------------------------------

    assign bvalid = (state == ST_RESPOND) & is_write;
    assign rvalid = (state == ST_RESPOND) & ~is_write;
    assign bresp  = resp;
    assign rresp  = resp;

    // the response leaves on the handshake of whichever channel is in use
    assign resp_taken = (bvalid & bready) | (rvalid & rready);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (write_fire || read_fire) begin
                        state <= ST_PENDING;
                    end
                end
                ST_PENDING: begin
                    if (done) begin
                        state <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    if (resp_taken) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // transaction fields and the captured answer stay stable until replaced
    always_ff @(posedge clock) begin
        if (write_fire) begin
            is_write <= 1'b1;
            addr     <= awaddr;
            wr_data  <= wdata;
            wr_strb  <= wstrb;
        end else if (read_fire) begin
            is_write <= 1'b0;
            addr     <= araddr;
        end
        if (done) begin
            rdata <= done_rdata;
            resp  <= done_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/reg_bank.sv ====
// ---------------------------------------------------------------------------
// eight-word register bank with byte strobes, word decode and range error
// ---------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module reg_bank (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           access,
    input  logic                           is_write,
    input  logic [hub_pkg::ADDR_WIDTH-1:0] addr,
    input  logic [hub_pkg::DATA_WIDTH-1:0] wr_data,
    input  logic [hub_pkg::STRB_WIDTH-1:0] wr_strb,
    output logic [hub_pkg::DATA_WIDTH-1:0] rd_data,
    output logic                           err
);

    import hub_pkg::*;

    logic [DATA_WIDTH-1:0]      regs [NUM_REGS];
    logic [REG_INDEX_WIDTH-1:0] index;
    logic                       write_en;

    // ------------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------------

    // byte address bits 4 to 2 pick the word; the low two bits are ignored
    assign index = addr[REG_INDEX_WIDTH+1:2];

    // anything past the last word of the bank is an error
    assign err = (addr >= ADDR_WIDTH'(NUM_REGS * STRB_WIDTH));

    // an erroring access must leave every register untouched
    assign write_en = access & is_write & ~err;

    // ------------------------------------------------------------------------
    // read path
    // ------------------------------------------------------------------------

    // reads are combinational so the answer is ready in the access cycle
    assign rd_data = err ? '0 : regs[index];

    // ------------------------------------------------------------------------
    // write path
    // ------------------------------------------------------------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (write_en) begin
            // only the bytes with their strobe set take the new value
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (wr_strb[b]) begin
                    regs[index][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rr_arbiter.sv ====
// ---------------------------------------------------------------------------
// round-robin arbiter built from a masked and a raw lowest-index pick,
// with the grant held in a register
// ---------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module rr_arbiter #(
    parameter int WORD_WIDTH = 3
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic [WORD_WIDTH-1:0] requests,
    output logic [WORD_WIDTH-1:0] grant
);

    logic [WORD_WIDTH-1:0] raw_pick;
    logic [WORD_WIDTH-1:0] mask;
    logic [WORD_WIDTH-1:0] requests_masked;
    logic [WORD_WIDTH-1:0] masked_pick;

    // ------------------------------------------------------------------------
    // raw pick
    // ------------------------------------------------------------------------

    // two's complement isolates the lowest set bit, so bit 0 wins first
    assign raw_pick = requests & (~requests + WORD_WIDTH'(1));

    // ------------------------------------------------------------------------
    // masked pick
    // ------------------------------------------------------------------------

    // thermometer mask covering the last granted index and everything above
    // it. A zero grant wraps to all ones and the inversion clears the mask
    assign mask = ~(grant - WORD_WIDTH'(1));

    // the holder stays inside the mask, so it keeps the grant while it asks
    assign requests_masked = requests & mask;

    assign masked_pick = requests_masked & (~requests_masked + WORD_WIDTH'(1));

    // ------------------------------------------------------------------------
    // grant register
    // ------------------------------------------------------------------------

    // when nothing at or above the last grant is left, fall back to the raw
    // pick so the rotation restarts from index 0
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            grant <= '0;
        end else if (masked_pick == '0) begin
            grant <= raw_pick;
        end else begin
            grant <= masked_pick;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/shared_reg_hub.sv ====
// ---------------------------------------------------------------------------
// top level of the hub: one AXI4-Lite port per requester, the round-robin
// arbiter, the grant mux and the shared register bank
// ---------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module shared_reg_hub (
    input  logic                                                 clock,
    input  logic                                                 rst_n,

    // write address and write data, one lane per requester
    input  logic [hub_pkg::NUM_PORTS-1:0]                        awvalid,
    output logic [hub_pkg::NUM_PORTS-1:0]                        awready,
    input  logic [hub_pkg::NUM_PORTS-1:0][hub_pkg::ADDR_WIDTH-1:0] awaddr,
    input  logic [hub_pkg::NUM_PORTS-1:0]                        wvalid,
    output logic [hub_pkg::NUM_PORTS-1:0]                        wready,
    input  logic [hub_pkg::NUM_PORTS-1:0][hub_pkg::DATA_WIDTH-1:0] wdata,
    input  logic [hub_pkg::NUM_PORTS-1:0][hub_pkg::STRB_WIDTH-1:0] wstrb,

    // write response
    output logic [hub_pkg::NUM_PORTS-1:0]                        bvalid,
    input  logic [hub_pkg::NUM_PORTS-1:0]                        bready,
    output logic [hub_pkg::NUM_PORTS-1:0][1:0]                   bresp,

    // read address
    input  logic [hub_pkg::NUM_PORTS-1:0]                        arvalid,
    output logic [hub_pkg::NUM_PORTS-1:0]                        arready,
    input  logic [hub_pkg::NUM_PORTS-1:0][hub_pkg::ADDR_WIDTH-1:0] araddr,

    // read data
    output logic [hub_pkg::NUM_PORTS-1:0]                        rvalid,
    input  logic [hub_pkg::NUM_PORTS-1:0]                        rready,
    output logic [hub_pkg::NUM_PORTS-1:0][hub_pkg::DATA_WIDTH-1:0] rdata,
    output logic [hub_pkg::NUM_PORTS-1:0][1:0]                   rresp
);

    import hub_pkg::*;

    // held transactions of every port
    logic [NUM_PORTS-1:0]                 port_request;
    logic [NUM_PORTS-1:0]                 port_is_write;
    logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0] port_addr;
    logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] port_wr_data;
    logic [NUM_PORTS-1:0][STRB_WIDTH-1:0] port_wr_strb;

    // arbitration and completion
    logic [NUM_PORTS-1:0]                 grant;
    logic [NUM_PORTS-1:0]                 done;
    logic                                 access;

    // fields of the granted port as seen by the bank
    logic                                 sel_is_write;
    logic [ADDR_WIDTH-1:0]                sel_addr;
    logic [DATA_WIDTH-1:0]                sel_wr_data;
    logic [STRB_WIDTH-1:0]                sel_wr_strb;
    logic [DATA_WIDTH-1:0]                bank_rdata;
    logic                                 bank_err;

    // ------------------------------------------------------------------------
    // requester ports
    // ------------------------------------------------------------------------

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        axil_port axil_port_inst (
            .clock      (clock),
            .rst_n      (rst_n),
            .awvalid    (awvalid[i]),
            .awready    (awready[i]),
            .awaddr     (awaddr[i]),
            .wvalid     (wvalid[i]),
            .wready     (wready[i]),
            .wdata      (wdata[i]),
            .wstrb      (wstrb[i]),
            .bvalid     (bvalid[i]),
            .bready     (bready[i]),
            .bresp      (bresp[i]),
            .arvalid    (arvalid[i]),
            .arready    (arready[i]),
            .araddr     (araddr[i]),
            .rvalid     (rvalid[i]),
            .rready     (rready[i]),
            .rdata      (rdata[i]),
            .rresp      (rresp[i]),
            .request    (port_request[i]),
            .is_write   (port_is_write[i]),
            .addr       (port_addr[i]),
            .wr_data    (port_wr_data[i]),
            .wr_strb    (port_wr_strb[i]),
            .done       (done[i]),
            .done_rdata (bank_rdata),
            .done_err   (bank_err)
        );
    end

    // ------------------------------------------------------------------------
    // arbitration
    // ------------------------------------------------------------------------

    rr_arbiter #(
        .WORD_WIDTH (NUM_PORTS)
    ) rr_arbiter_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .requests   (port_request),
        .grant      (grant)
    );

    // a grant only counts while its holder still requests. This drops the
    // stale grant left for one cycle after the holder has been served
    assign done   = grant & port_request;
    assign access = |done;

    // ------------------------------------------------------------------------
    // grant mux
    // ------------------------------------------------------------------------

    // the grant is one-hot or zero, so an AND-OR selection is enough
    always_comb begin
        sel_is_write = 1'b0;
        sel_addr     = '0;
        sel_wr_data  = '0;
        sel_wr_strb  = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (grant[i]) begin
                sel_is_write = sel_is_write | port_is_write[i];
                sel_addr     = sel_addr | port_addr[i];
                sel_wr_data  = sel_wr_data | port_wr_data[i];
                sel_wr_strb  = sel_wr_strb | port_wr_strb[i];
            end
        end
    end

    // ------------------------------------------------------------------------
    // register bank
    // ------------------------------------------------------------------------

    reg_bank reg_bank_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .access   (access),
        .is_write (sel_is_write),
        .addr     (sel_addr),
        .wr_data  (sel_wr_data),
        .wr_strb  (sel_wr_strb),
        .rd_data  (bank_rdata),
        .err      (bank_err)
    );

endmodule

`default_nettype wire
